// File: rtl/cfg_loader_pkg.sv
// Sizes, widths, address-field positions, register offsets and command selector codes
package cfg_loader_pkg;

  // ======================================================================
  // Sizes and widths
  // ======================================================================
  localparam int num_tiles        = 2;
  localparam int tile_id_width    = 4;
  localparam int addr_width       = 32;
  localparam int data_width       = 64;
  localparam int cfg_addr_width   = 16;
  localparam int ucode_els        = 16;
  localparam int ucode_addr_width = 4;
  localparam int max_credits      = 4;
  localparam int credit_width     = 3;
  localparam int sync_cycles      = 16;
  localparam int sync_cnt_width   = 5;  // Counts 0 to sync_cycles
  localparam int src_id_width     = 4;

  // ======================================================================
  // Address fields
  // ======================================================================
  localparam int tile_lsb  = 24;  // Tile at 27:24
  localparam int dev_lsb   = 20;  // Device at 23:20
  localparam int dev_width = 4;
  localparam logic [dev_width-1:0] cfg_dev = 4'd2;

  // ======================================================================
  // Register offsets and values
  // ======================================================================
  localparam logic [cfg_addr_width-1:0] reg_reset       = 16'h0004;
  localparam logic [cfg_addr_width-1:0] reg_freeze      = 16'h0008;
  localparam logic [cfg_addr_width-1:0] reg_domain_mask = 16'h0010;
  localparam logic [cfg_addr_width-1:0] reg_icache_mode = 16'h0020;
  localparam logic [cfg_addr_width-1:0] reg_dcache_mode = 16'h0024;
  localparam logic [cfg_addr_width-1:0] reg_cce_mode    = 16'h0028;
  localparam logic [cfg_addr_width-1:0] ucode_base      = 16'h8000;  // Word k at base + k

  localparam logic [data_width-1:0] mode_normal = 64'd1;
  localparam logic [data_width-1:0] domain_mask = 64'h0000_0000_0000_0001;

  // Which command the encoder builds, independent of controller state
  typedef enum logic [3:0] {
    sel_reset_set,
    sel_freeze_set,
    sel_reset_clr,
    sel_ucode,
    sel_icache,
    sel_dcache,
    sel_cce,
    sel_domain,
    sel_freeze_clr
  } cmd_sel_t;

endpackage

// File: rtl/cfg_credit_tracker.sv
// Outstanding-command counter with full and empty flags
`timescale 1ns/1ps

module cfg_credit_tracker (
  input  logic clk_i,
  input  logic reset_i,
  input  logic sent_i,
  input  logic returned_i,
  output logic credits_full_o,
  output logic credits_empty_o
);

  logic [cfg_loader_pkg::credit_width-1:0] count_r;

  assign credits_full_o  = (count_r == cfg_loader_pkg::credit_width'(cfg_loader_pkg::max_credits));
  assign credits_empty_o = (count_r == '0);

  // Send and return together cancel out
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      count_r <= '0;
    end else if (sent_i && !returned_i && !credits_full_o) begin
      count_r <= count_r + 1'b1;
    end else if (returned_i && !sent_i && !credits_empty_o) begin
      count_r <= count_r - 1'b1;
    end
  end

endmodule

// File: rtl/cfg_ucode_rom.sv
// Microcode boot ROM with combinational, bit-reversed read
`timescale 1ns/1ps

module cfg_ucode_rom (
  input  logic [cfg_loader_pkg::ucode_addr_width-1:0] idx_i,
  output logic [cfg_loader_pkg::data_width-1:0]       word_o
);

  logic [cfg_loader_pkg::data_width-1:0] rom [cfg_loader_pkg::ucode_els];
  logic [cfg_loader_pkg::data_width-1:0] raw_word;

  initial begin
    $readmemb("test/cfg_ucode.mem", rom);
  end

  assign raw_word = rom[idx_i];

  // Image is stored LSB first
  always_comb begin
    for (int b = 0; b < cfg_loader_pkg::data_width; b++) begin
      word_o[b] = raw_word[cfg_loader_pkg::data_width-1-b];
    end
  end

endmodule

// File: rtl/cfg_cmd_encoder.sv
// Command address and data encoder for config writes
`timescale 1ns/1ps

module cfg_cmd_encoder (
  input  cfg_loader_pkg::cmd_sel_t                    cmd_sel_i,
  input  logic [cfg_loader_pkg::tile_id_width-1:0]    tile_idx_i,
  input  logic [cfg_loader_pkg::ucode_addr_width-1:0] ucode_idx_i,
  input  logic [cfg_loader_pkg::data_width-1:0]       ucode_word_i,
  output logic [cfg_loader_pkg::addr_width-1:0]       addr_o,
  output logic [cfg_loader_pkg::data_width-1:0]       data_o
);

  logic [cfg_loader_pkg::cfg_addr_width-1:0] offset;

  // Register offset and write value per selector
  always_comb begin
    offset = '0;
    data_o = '0;
    case (cmd_sel_i)
      cfg_loader_pkg::sel_reset_set: begin
        offset = cfg_loader_pkg::reg_reset;
        data_o = cfg_loader_pkg::data_width'(1);
      end
      cfg_loader_pkg::sel_freeze_set: begin
        offset = cfg_loader_pkg::reg_freeze;
        data_o = cfg_loader_pkg::data_width'(1);
      end
      cfg_loader_pkg::sel_reset_clr:  offset = cfg_loader_pkg::reg_reset;
      cfg_loader_pkg::sel_freeze_clr: offset = cfg_loader_pkg::reg_freeze;
      cfg_loader_pkg::sel_ucode: begin
        offset = cfg_loader_pkg::ucode_base
               + cfg_loader_pkg::cfg_addr_width'(ucode_idx_i);
        data_o = ucode_word_i;
      end
      cfg_loader_pkg::sel_icache: begin
        offset = cfg_loader_pkg::reg_icache_mode;
        data_o = cfg_loader_pkg::mode_normal;
      end
      cfg_loader_pkg::sel_dcache: begin
        offset = cfg_loader_pkg::reg_dcache_mode;
        data_o = cfg_loader_pkg::mode_normal;
      end
      cfg_loader_pkg::sel_cce: begin
        offset = cfg_loader_pkg::reg_cce_mode;
        data_o = cfg_loader_pkg::mode_normal;
      end
      cfg_loader_pkg::sel_domain: begin
        offset = cfg_loader_pkg::reg_domain_mask;
        data_o = cfg_loader_pkg::domain_mask;
      end
      default: begin
        offset = '0;
        data_o = '0;
      end
    endcase
  end

  // Tile, device and offset fields; upper nibble and 19:16 stay zero
  always_comb begin
    addr_o = '0;
    addr_o[cfg_loader_pkg::tile_lsb +: cfg_loader_pkg::tile_id_width] = tile_idx_i;
    addr_o[cfg_loader_pkg::dev_lsb +: cfg_loader_pkg::dev_width]      = cfg_loader_pkg::cfg_dev;
    addr_o[cfg_loader_pkg::cfg_addr_width-1:0]                        = offset;
  end

endmodule

// File: rtl/cfg_loader_ctrl.sv
// Bring-up FSM with tile, microcode and sync counters
`timescale 1ns/1ps

module cfg_loader_ctrl (
  input  logic                                          clk_i,
  input  logic                                          reset_i,
  input  logic                                          credits_full_i,
  input  logic                                          credits_empty_i,
  input  logic                                          cmd_yumi_i,
  output logic                                          cmd_v_o,
  output cfg_loader_pkg::cmd_sel_t                      cmd_sel_o,
  output logic [cfg_loader_pkg::tile_id_width-1:0]      tile_idx_o,
  output logic [cfg_loader_pkg::ucode_addr_width-1:0]   ucode_idx_o,
  output logic                                          done_o
);

  typedef enum logic [3:0] {
    s_idle,
    s_reset_set,
    s_freeze_set,
    s_reset_clr,
    s_ucode,
    s_icache,
    s_dcache,
    s_cce,
    s_sync,
    s_domain,
    s_freeze_clr,
    s_wait_credits,
    s_done
  } state_t;

  state_t state_r, state_n;
  state_t after_tiles;  // Where to go once the last tile is written

  logic [cfg_loader_pkg::tile_id_width-1:0]    tile_r, tile_n;
  logic [cfg_loader_pkg::ucode_addr_width-1:0] ucode_r, ucode_n;
  logic [cfg_loader_pkg::sync_cnt_width-1:0]   sync_r, sync_n;

  logic want_v;
  logic need_empty;
  logic tile_step;
  logic cmd_fire;
  logic tile_last;
  logic ucode_last;
  logic sync_done;

  assign tile_last  = (tile_r == cfg_loader_pkg::tile_id_width'(cfg_loader_pkg::num_tiles - 1));
  assign ucode_last = (ucode_r == cfg_loader_pkg::ucode_addr_width'(cfg_loader_pkg::ucode_els - 1));
  assign sync_done  = (sync_r == cfg_loader_pkg::sync_cnt_width'(cfg_loader_pkg::sync_cycles));

  // Mode and domain writes go out only with nothing in flight
  assign cmd_v_o  = want_v & ~credits_full_i & (~need_empty | credits_empty_i);
  assign cmd_fire = cmd_v_o & cmd_yumi_i;

  assign tile_idx_o  = tile_r;
  assign ucode_idx_o = ucode_r;
  assign done_o      = (state_r == s_done);

  // ======================================================================
  // Next state and counter updates
  // ======================================================================
  always_comb begin
    state_n     = state_r;
    tile_n      = tile_r;
    ucode_n     = ucode_r;
    sync_n      = sync_r;
    after_tiles = state_r;
    want_v      = 1'b0;
    need_empty  = 1'b0;
    tile_step   = 1'b0;
    cmd_sel_o   = cfg_loader_pkg::sel_reset_set;

    case (state_r)
      s_idle: state_n = s_reset_set;
      s_reset_set: begin
        want_v      = 1'b1;
        tile_step   = 1'b1;
        after_tiles = s_freeze_set;
      end
      s_freeze_set: begin
        want_v      = 1'b1;
        tile_step   = 1'b1;
        cmd_sel_o   = cfg_loader_pkg::sel_freeze_set;
        after_tiles = s_reset_clr;
      end
      s_reset_clr: begin
        want_v      = 1'b1;
        tile_step   = 1'b1;
        cmd_sel_o   = cfg_loader_pkg::sel_reset_clr;
        after_tiles = s_ucode;
      end
      s_ucode: begin
        want_v      = 1'b1;
        tile_step   = ucode_last;  // Tile moves after its last word
        cmd_sel_o   = cfg_loader_pkg::sel_ucode;
        after_tiles = s_icache;
        if (cmd_fire) begin
          ucode_n = ucode_last ? '0 : ucode_r + 1'b1;
        end
      end
      s_icache: begin
        want_v      = 1'b1;
        need_empty  = 1'b1;
        tile_step   = 1'b1;
        cmd_sel_o   = cfg_loader_pkg::sel_icache;
        after_tiles = s_dcache;
      end
      s_dcache: begin
        want_v      = 1'b1;
        need_empty  = 1'b1;
        tile_step   = 1'b1;
        cmd_sel_o   = cfg_loader_pkg::sel_dcache;
        after_tiles = s_cce;
      end
      s_cce: begin
        want_v      = 1'b1;
        need_empty  = 1'b1;
        tile_step   = 1'b1;
        cmd_sel_o   = cfg_loader_pkg::sel_cce;
        after_tiles = s_sync;
      end
      s_sync: begin  // sync_cycles + 1 idle cycles
        sync_n = sync_done ? '0 : sync_r + 1'b1;
        if (sync_done) begin
          state_n = s_domain;
        end
      end
      s_domain: begin
        want_v      = 1'b1;
        need_empty  = 1'b1;
        tile_step   = 1'b1;
        cmd_sel_o   = cfg_loader_pkg::sel_domain;
        after_tiles = s_freeze_clr;
      end
      s_freeze_clr: begin
        want_v      = 1'b1;
        tile_step   = 1'b1;
        cmd_sel_o   = cfg_loader_pkg::sel_freeze_clr;
        after_tiles = s_wait_credits;
      end
      s_wait_credits: if (credits_empty_i) state_n = s_done;
      s_done: state_n = s_done;
      default: state_n = s_idle;
    endcase

    // Shared tile loop for every per-tile command
    if (cmd_fire && tile_step) begin
      if (tile_last) begin
        tile_n  = '0;
        state_n = after_tiles;
      end else begin
        tile_n = tile_r + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= s_idle;
      tile_r  <= '0;
      ucode_r <= '0;
      sync_r  <= '0;
    end else begin
      state_r <= state_n;
      tile_r  <= tile_n;
      ucode_r <= ucode_n;
      sync_r  <= sync_n;
    end
  end

endmodule

// File: rtl/cfg_loader_top.sv
// Config loader top level joining FSM, credit tracker, boot ROM and encoder
`timescale 1ns/1ps

module cfg_loader_top (
  input  logic                                      clk_i,
  input  logic                                      reset_i,
  input  logic [cfg_loader_pkg::src_id_width-1:0]   src_id_i,

  output logic                                      cmd_v_o,
  output logic [cfg_loader_pkg::addr_width-1:0]     cmd_addr_o,
  output logic [cfg_loader_pkg::data_width-1:0]     cmd_data_o,
  output logic [cfg_loader_pkg::src_id_width-1:0]   cmd_src_o,
  input  logic                                      cmd_yumi_i,

  input  logic                                      resp_v_i,
  output logic                                      done_o
);

  cfg_loader_pkg::cmd_sel_t                    cmd_sel;
  logic [cfg_loader_pkg::tile_id_width-1:0]    tile_idx;
  logic [cfg_loader_pkg::ucode_addr_width-1:0] ucode_idx;
  logic [cfg_loader_pkg::data_width-1:0]       ucode_word;
  logic                                        credits_full;
  logic                                        credits_empty;
  logic                                        cmd_sent;

  assign cmd_sent  = cmd_v_o & cmd_yumi_i;  // One transfer
  assign cmd_src_o = src_id_i;

  cfg_loader_ctrl i_ctrl (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .credits_full_i (credits_full),
    .credits_empty_i(credits_empty),
    .cmd_yumi_i     (cmd_yumi_i),
    .cmd_v_o        (cmd_v_o),
    .cmd_sel_o      (cmd_sel),
    .tile_idx_o     (tile_idx),
    .ucode_idx_o    (ucode_idx),
    .done_o         (done_o)
  );

  cfg_credit_tracker i_credits (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .sent_i         (cmd_sent),
    .returned_i     (resp_v_i),
    .credits_full_o (credits_full),
    .credits_empty_o(credits_empty)
  );

  cfg_ucode_rom i_rom (
    .idx_i (ucode_idx),
    .word_o(ucode_word)
  );

  cfg_cmd_encoder i_encoder (
    .cmd_sel_i   (cmd_sel),
    .tile_idx_i  (tile_idx),
    .ucode_idx_i (ucode_idx),
    .ucode_word_i(ucode_word),
    .addr_o      (cmd_addr_o),
    .data_o      (cmd_data_o)
  );

endmodule

// File: test/cfg_loader_props.sv
// Bound assertions on the command credit limit and the valid/yumi handshake
`timescale 1ns/1ps

module cfg_loader_props (
  input logic                                  clk_i,
  input logic                                  reset_i,
  input logic                                  cmd_v_i,
  input logic                                  yumi_i,
  input logic                                  resp_v_i,
  input logic [cfg_loader_pkg::addr_width-1:0] cmd_addr_i,
  input logic [cfg_loader_pkg::data_width-1:0] cmd_data_i
);

  int in_flight;  // Transfers minus responses

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      in_flight <= 0;
    end else begin
      in_flight <= in_flight + int'(cmd_v_i & yumi_i) - int'(resp_v_i);
    end
  end

  credit_limit: assert property (@(posedge clk_i) disable iff (reset_i)
    in_flight <= cfg_loader_pkg::max_credits)
    else $error("More commands in flight than the credit limit");

  held_cmd_stable: assert property (@(posedge clk_i) disable iff (reset_i)
    cmd_v_i && !yumi_i |=> cmd_v_i && $stable(cmd_addr_i) && $stable(cmd_data_i))
    else $error("Command changed while waiting for yumi");

endmodule

bind cfg_loader_top cfg_loader_props i_props (
  .clk_i     (clk_i),
  .reset_i   (reset_i),
  .cmd_v_i   (cmd_v_o),
  .yumi_i    (cmd_yumi_i),
  .resp_v_i  (resp_v_i),
  .cmd_addr_i(cmd_addr_o),
  .cmd_data_i(cmd_data_o)
);

// File: test/tb_cfg_loader.sv
// Testbench with clock, reset, network and tile model, command checks and watchdog
`timescale 1ns/1ps

module tb_cfg_loader;

  localparam int num_cmds       = 48;
  localparam int half_period    = 50;
  localparam int post_cycles    = 20;
  localparam int timeout_cycles = num_cmds * (8 + 8) + cfg_loader_pkg::sync_cycles + 100;

  logic                                    clk_i;
  logic                                    reset_i;
  logic [cfg_loader_pkg::src_id_width-1:0] src_id_i;
  logic                                    cmd_v_o;
  logic [cfg_loader_pkg::addr_width-1:0]   cmd_addr_o;
  logic [cfg_loader_pkg::data_width-1:0]   cmd_data_o;
  logic [cfg_loader_pkg::src_id_width-1:0] cmd_src_o;
  logic                                    cmd_yumi_i;
  logic                                    resp_v_i;
  logic                                    done_o;

  logic [95:0] expected [num_cmds];  // Address in 95:64, data in 63:0
  logic [31:0] lfsr_state     = 32'he52bf7d7;
  int          resp_due [$];         // Earliest cycle of each pending response
  int          errors         = 0;
  int          checks         = 0;
  int          cycle          = 0;
  int          sent_count     = 0;
  int          resp_count     = 0;
  int          outstanding    = 0;
  int          all_back_cycle = 0;
  int          full_cycles    = 0;
  int          gap            = 0;
  int          after_done     = 0;
  logic        fire_r         = 1'b0;
  logic        resp_r         = 1'b0;
  logic        held_r         = 1'b0;
  logic        hold_resp      = 1'b1;  // Withheld until credits run out
  logic        gap_open       = 1'b0;
  logic        timed_out      = 1'b0;
  logic [cfg_loader_pkg::addr_width-1:0] held_addr = '0;
  logic [cfg_loader_pkg::data_width-1:0] held_data = '0;

  cfg_loader_top i_dut (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .src_id_i  (src_id_i),
    .cmd_v_o   (cmd_v_o),
    .cmd_addr_o(cmd_addr_o),
    .cmd_data_o(cmd_data_o),
    .cmd_src_o (cmd_src_o),
    .cmd_yumi_i(cmd_yumi_i),
    .resp_v_i  (resp_v_i),
    .done_o    (done_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #(half_period) clk_i = ~clk_i;
  end

  // x^32 + x^22 + x^2 + x + 1, one step per bit
  function automatic int take_bits(input int n);
    int   result;
    int   i;
    logic feedback;
    result = 0;
    for (i = 0; i < n; i++) begin
      feedback   = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], feedback};
      result     = (result << 1) | {31'd0, lfsr_state[0]};
    end
    return result;
  endfunction

  task automatic check_value(input string name, input logic [63:0] actual,
                             input logic [63:0] want);
    checks++;
    if (actual !== want) begin
      errors++;
      $display("CHECK FAILED: %s actual=0x%h expected=0x%h at %0t", name, actual, want, $time);
    end
  endtask

  task automatic finish_run();
    $display("Summary: %0d checks, %0d errors, %0d commands, %0d responses",
             checks, errors, sent_count, resp_count);
    if (errors == 0 && !timed_out) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  endtask

  // ====================================================================
  // One falling edge: account, check, drive
  // ====================================================================
  task automatic step_cycle();
    logic [cfg_loader_pkg::addr_width-1:0]     exp_addr;
    logic [cfg_loader_pkg::data_width-1:0]     exp_data;
    logic [cfg_loader_pkg::cfg_addr_width-1:0] exp_offset;
    logic                                      mode_write;
    logic                                      grant;
    int                                        delay;

    cycle++;
    outstanding = outstanding + int'(fire_r) - int'(resp_r);
    resp_count  = resp_count + int'(resp_r);
    if (resp_r && resp_count == num_cmds) begin
      all_back_cycle = cycle;
    end

    {exp_addr, exp_data} = '0;
    if (sent_count < num_cmds) begin
      {exp_addr, exp_data} = expected[sent_count];
    end
    exp_offset = exp_addr[cfg_loader_pkg::cfg_addr_width-1:0];
    mode_write = (exp_offset == cfg_loader_pkg::reg_icache_mode)
              || (exp_offset == cfg_loader_pkg::reg_dcache_mode)
              || (exp_offset == cfg_loader_pkg::reg_cce_mode)
              || (exp_offset == cfg_loader_pkg::reg_domain_mask);

    check_value("outstanding within limit",
                64'(outstanding <= cfg_loader_pkg::max_credits), 64'd1);
    if (outstanding == cfg_loader_pkg::max_credits) begin
      check_value("cmd_v_o with credits full", 64'(cmd_v_o), 64'd0);
    end
    if (sent_count >= num_cmds) begin
      check_value("cmd_v_o after last command", 64'(cmd_v_o), 64'd0);
    end
    check_value("done_o", 64'(done_o), 64'(resp_count == num_cmds && cycle > all_back_cycle));
    if (held_r) begin  // Command must not move without yumi
      check_value("cmd_v_o while held", 64'(cmd_v_o), 64'd1);
      check_value("cmd_addr_o while held", 64'(cmd_addr_o), 64'(held_addr));
      check_value("cmd_data_o while held", cmd_data_o, held_data);
    end

    if (gap_open && !cmd_v_o) begin
      gap++;
    end
    if (gap_open && cmd_v_o && exp_offset == cfg_loader_pkg::reg_domain_mask) begin
      check_value("sync gap long enough", 64'(gap >= cfg_loader_pkg::sync_cycles), 64'd1);
      gap_open = 1'b0;
    end

    grant = 1'b0;
    if (cmd_v_o) begin
      grant = hold_resp ? 1'b1 : (take_bits(2) != 0);
    end
    if (grant) begin
      check_value("cmd_addr_o", 64'(cmd_addr_o), 64'(exp_addr));
      check_value("cmd_data_o", cmd_data_o, exp_data);
      check_value("cmd_src_o", 64'(cmd_src_o), 64'(src_id_i));
      if (mode_write) begin
        check_value("outstanding at mode write", 64'(outstanding), 64'd0);
      end
      if (exp_offset == cfg_loader_pkg::reg_cce_mode) begin
        gap_open = 1'b1;
        gap      = 0;
      end
      delay = take_bits(3);
      resp_due.push_back(cycle + 1 + delay);
      sent_count++;
    end

    if (hold_resp && outstanding == cfg_loader_pkg::max_credits) begin
      full_cycles++;
      hold_resp = (full_cycles < 4);
    end

    resp_v_i = 1'b0;
    if (!hold_resp && resp_due.size() > 0) begin
      if (resp_due[0] <= cycle) begin
        resp_v_i = 1'b1;
        void'(resp_due.pop_front());
      end
    end

    cmd_yumi_i = grant;
    fire_r     = grant;
    resp_r     = resp_v_i;
    held_r     = cmd_v_o & ~grant;
    held_addr  = cmd_addr_o;
    held_data  = cmd_data_o;
  endtask

  // ====================================================================
  // Main sequence and watchdog
  // ====================================================================
  initial begin
    $readmemh("test/cfg_loader_testdata.mem", expected);
    reset_i    = 1'b1;
    src_id_i   = 4'h9;
    cmd_yumi_i = 1'b0;
    resp_v_i   = 1'b0;
    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    check_value("cmd_v_o in reset", 64'(cmd_v_o), 64'd0);
    check_value("done_o in reset", 64'(done_o), 64'd0);
    reset_i = 1'b0;
    while (after_done < post_cycles) begin
      @(negedge clk_i);
      step_cycle();
      if (done_o) begin
        after_done++;
      end
    end
    finish_run();
  end

  initial begin
    repeat (timeout_cycles) @(posedge clk_i);
    $display("Timeout: the loader never finished within %0d cycles", timeout_cycles);
    timed_out = 1'b1;
    finish_run();
  end

endmodule

// File: test/cfg_loader_testdata.mem
// Expected commands in transfer order: address (8 hex digits) _ data (16 hex digits)
00200004_0000000000000001
01200004_0000000000000001
00200008_0000000000000001
01200008_0000000000000001
00200004_0000000000000000
01200004_0000000000000000
00208000_C0DE000000000000
00208001_C0DE000000000001
00208002_C0DE000000000002
00208003_C0DE000000000003
00208004_C0DE000000000004
00208005_C0DE000000000005
00208006_C0DE000000000006
00208007_C0DE000000000007
00208008_C0DE000000000008
00208009_C0DE000000000009
0020800A_C0DE00000000000A
0020800B_C0DE00000000000B
0020800C_C0DE00000000000C
0020800D_C0DE00000000000D
0020800E_C0DE00000000000E
0020800F_C0DE00000000000F
01208000_C0DE000000000000
01208001_C0DE000000000001
01208002_C0DE000000000002
01208003_C0DE000000000003
01208004_C0DE000000000004
01208005_C0DE000000000005
01208006_C0DE000000000006
01208007_C0DE000000000007
01208008_C0DE000000000008
01208009_C0DE000000000009
0120800A_C0DE00000000000A
0120800B_C0DE00000000000B
0120800C_C0DE00000000000C
0120800D_C0DE00000000000D
0120800E_C0DE00000000000E
0120800F_C0DE00000000000F
00200020_0000000000000001
01200020_0000000000000001
00200024_0000000000000001
01200024_0000000000000001
00200028_0000000000000001
01200028_0000000000000001
00200010_0000000000000001
01200010_0000000000000001
00200008_0000000000000000
01200008_0000000000000000

// File: test/cfg_ucode.mem
// Microcode image, one 64-bit word per line, bits stored in reverse order
0000_0000_0000_0000_0000_0000_0000_0000_0000_0000_0000_0000_0111_1011_0000_0011
1000_0000_0000_0000_0000_0000_0000_0000_0000_0000_0000_0000_0111_1011_0000_0011
0100_0000_0000_0000_0000_0000_0000_0000_0000_0000_0000_0000_0111_1011_0000_0011
1100_0000_0000_0000_0000_0000_0000_0000_0000_0000_0000_0000_0111_1011_0000_0011
0010_0000_0000_0000_0000_0000_0000_0000_0000_0000_0000_0000_0111_1011_0000_0011
1010_0000_0000_0000_0000_0000_0000_0000_0000_0000_0000_0000_0111_1011_0000_0011
0110_0000_0000_0000_0000_0000_0000_0000_0000_0000_0000_0000_0111_1011_0000_0011
1110_0000_0000_0000_0000_0000_0000_0000_0000_0000_0000_0000_0111_1011_0000_0011
0001_0000_0000_0000_0000_0000_0000_0000_0000_0000_0000_0000_0111_1011_0000_0011
1001_0000_0000_0000_0000_0000_0000_0000_0000_0000_0000_0000_0111_1011_0000_0011
0101_0000_0000_0000_0000_0000_0000_0000_0000_0000_0000_0000_0111_1011_0000_0011
1101_0000_0000_0000_0000_0000_0000_0000_0000_0000_0000_0000_0111_1011_0000_0011
0011_0000_0000_0000_0000_0000_0000_0000_0000_0000_0000_0000_0111_1011_0000_0011
1011_0000_0000_0000_0000_0000_0000_0000_0000_0000_0000_0000_0111_1011_0000_0011
0111_0000_0000_0000_0000_0000_0000_0000_0000_0000_0000_0000_0111_1011_0000_0011
1111_0000_0000_0000_0000_0000_0000_0000_0000_0000_0000_0000_0111_1011_0000_0011

// File: tb.f
rtl/cfg_loader_pkg.sv
rtl/cfg_credit_tracker.sv
rtl/cfg_ucode_rom.sv
rtl/cfg_cmd_encoder.sv
rtl/cfg_loader_ctrl.sv
rtl/cfg_loader_top.sv
test/cfg_loader_props.sv
test/tb_cfg_loader.sv

// File: Makefile
SIM       := verilator
TOP       := tb_cfg_loader
FILELIST  := tb.f
SIM_FLAGS := --binary --timing --assert --top-module $(TOP)
RUN_FLAGS := +verilator+error+limit+100
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST))
PASS_MSG  := TEST RESULT: PASS

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(SIM_FLAGS) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN) $(RUN_FLAGS))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
